/* common/i2c_pkg.sv */
package i2c_pkg;

    // --------------------
    // widths with a meaning
    // --------------------
    typedef logic [6:0]  slave_addr_t;   // 7-bit device address
    typedef logic [15:0] word_addr_t;    // word address inside the device
    typedef logic [7:0]  data_t;         // one data byte
    typedef logic [5:0]  phase_cnt_t;    // cycle count within a phase

    // one command from the user side, 26 bits
    typedef struct packed {
        logic       rh_wl;     // 1 read, 0 write
        logic       bit_ctrl;  // 1 two address bytes, 0 one
        word_addr_t addr;
        data_t      wdata;
    } i2c_cmd_t;

    // --------------------
    // wire phases
    // --------------------
    typedef enum logic [2:0] {
        pk_start_addr,    // START then a byte
        pk_restart_addr,  // repeated START then a byte
        pk_tx_byte,       // byte out, then ack slot
        pk_rx_byte,       // byte in, then NACK
        pk_stop           // STOP
    } phase_kind_e;

    // request from sequencer to bit engine, 11 bits
    typedef struct packed {
        phase_kind_e kind;
        data_t       tx_byte;
    } phase_req_t;

    // phase lengths in dri_clk cycles, four cycles per SCL period
    localparam phase_cnt_t ADDR_PHASE_LEN = 6'd40;  // start/restart + 8 bits + ack
    localparam phase_cnt_t BYTE_PHASE_LEN = 6'd36;  // 8 bits + ack/nack
    localparam phase_cnt_t STOP_PHASE_LEN = 6'd17;  // stop condition and bus free time

endpackage

/* i2c/i2c_txn_seq.sv */
`timescale 1ns/1ps

module i2c_txn_seq #(
    parameter i2c_pkg::slave_addr_t SLAVE_ADDR = 7'b1010000
) (
    input  logic                 dri_clk,
    input  logic                 rst_n,

    input  logic                 i2c_exec,
    input  i2c_pkg::i2c_cmd_t    i2c_cmd,

    output i2c_pkg::phase_req_t  phase_req,
    output logic                 phase_valid,
    input  logic                 phase_done,
    input  i2c_pkg::data_t       rx_byte,

    output i2c_pkg::data_t       i2c_data_r,
    output logic                 i2c_done
);

    import i2c_pkg::*;

    typedef enum logic [2:0] {
        idle,
        sladdr,    // device address, write bit
        addr16,    // word address high byte
        addr8,     // word address low byte
        data_wr,
        addr_rd,   // device address again, read bit
        data_rd,
        stop
    } seq_state_e;

    seq_state_e state_q;
    seq_state_e state_d;
    i2c_cmd_t   cmd_q;
    logic       accept;

    // exec only counts in idle, and not in the done cycle
    assign accept = (state_q == idle) && i2c_exec && !i2c_done;

    // --------------------
    // state machine
    // --------------------
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            idle:    if (accept) state_d = sladdr;
            sladdr:  if (phase_done) state_d = cmd_q.bit_ctrl ? addr16 : addr8;
            addr16:  if (phase_done) state_d = addr8;
            addr8:   if (phase_done) state_d = cmd_q.rh_wl ? addr_rd : data_wr;
            data_wr: if (phase_done) state_d = stop;
            addr_rd: if (phase_done) state_d = data_rd;
            data_rd: if (phase_done) state_d = stop;
            stop:    if (phase_done) state_d = idle;
            default: state_d = idle;
        endcase
    end

    // command is held for the whole transaction
    always_ff @(posedge dri_clk) begin
        if (accept) begin
            cmd_q <= i2c_cmd;
        end
    end

    // --------------------
    // phase request
    // --------------------
    assign phase_valid = (state_q != idle);

    always_comb begin
        phase_req.kind    = pk_stop;
        phase_req.tx_byte = '0;
        case (state_q)
            sladdr: begin
                phase_req.kind    = pk_start_addr;
                phase_req.tx_byte = {SLAVE_ADDR, 1'b0};  // write
            end
            addr16: begin
                phase_req.kind    = pk_tx_byte;
                phase_req.tx_byte = cmd_q.addr[15:8];
            end
            addr8: begin
                phase_req.kind    = pk_tx_byte;
                phase_req.tx_byte = cmd_q.addr[7:0];
            end
            data_wr: begin
                phase_req.kind    = pk_tx_byte;
                phase_req.tx_byte = cmd_q.wdata;
            end
            addr_rd: begin
                phase_req.kind    = pk_restart_addr;
                phase_req.tx_byte = {SLAVE_ADDR, 1'b1};  // read
            end
            data_rd: phase_req.kind = pk_rx_byte;
            default: ;                                   // stop, idle
        endcase
    end

    // --------------------
    // results
    // --------------------
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            i2c_done <= 1'b0;
        end else begin
            i2c_done <= (state_q == stop) && phase_done;  // one cycle after stop ends
        end
    end

    always_ff @(posedge dri_clk) begin
        if ((state_q == data_rd) && phase_done) begin
            i2c_data_r <= rx_byte;  // held until next read
        end
    end

    a_done_single : assert property (@(posedge dri_clk) disable iff (!rst_n)
        i2c_done |=> !i2c_done);

    // engine must only finish a phase it was given
    a_done_in_phase : assert property (@(posedge dri_clk) disable iff (!rst_n)
        phase_done |-> phase_valid);

endmodule

/* i2c/i2c_bit_engine.sv */
`timescale 1ns/1ps

module i2c_bit_engine (
    input  logic                 dri_clk,
    input  logic                 rst_n,

    input  i2c_pkg::phase_req_t  phase_req,
    input  logic                 phase_valid,
    output logic                 phase_done,
    output i2c_pkg::data_t       rx_byte,

    output logic                 scl,
    output logic                 sda_out,
    output logic                 sda_oe,
    input  logic                 sda_in
);

    import i2c_pkg::*;

    phase_cnt_t phase_cnt;
    phase_cnt_t phase_last;
    phase_cnt_t bit_cnt;    // position inside the byte part of the phase
    logic [2:0] bit_idx;
    logic       is_addr;
    logic       is_restart;
    logic       is_rx;
    data_t      rx_shift;

    assign is_restart = (phase_req.kind == pk_restart_addr);
    assign is_addr    = (phase_req.kind == pk_start_addr) || is_restart;
    assign is_rx      = (phase_req.kind == pk_rx_byte);

    // address phases carry a 4-cycle start prologue ahead of the byte
    assign bit_cnt = is_addr ? phase_cnt - 6'd4 : phase_cnt;
    assign bit_idx = 3'd7 - bit_cnt[4:2];  // msb first

    // --------------------
    // phase counter
    // --------------------
    always_comb begin
        case (phase_req.kind)
            pk_start_addr,
            pk_restart_addr: phase_last = ADDR_PHASE_LEN - 6'd1;
            pk_stop:         phase_last = STOP_PHASE_LEN - 6'd1;
            default:         phase_last = BYTE_PHASE_LEN - 6'd1;
        endcase
    end

    assign phase_done = phase_valid && (phase_cnt == phase_last);

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_cnt <= '0;
        end else if (!phase_valid || phase_done) begin
            phase_cnt <= '0;  // next phase starts at 0 without a gap
        end else begin
            phase_cnt <= phase_cnt + 6'd1;
        end
    end

    // --------------------
    // scl / sda schedule
    // --------------------
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            scl     <= 1'b1;
            sda_out <= 1'b1;
            sda_oe  <= 1'b1;
        end else if (!phase_valid) begin
            scl     <= 1'b1;  // bus idle, both lines high
            sda_out <= 1'b1;
            sda_oe  <= 1'b1;
        end else if (phase_req.kind == pk_stop) begin
            case (phase_cnt)
                6'd0: begin
                    sda_oe  <= 1'b1;
                    sda_out <= 1'b0;
                end
                6'd1:    scl     <= 1'b1;
                6'd3:    sda_out <= 1'b1;  // sda rises with scl high
                default: ;
            endcase
        end else if (is_addr && (phase_cnt < 6'd4)) begin
            // start or repeated start
            case (phase_cnt[1:0])
                2'd0: begin
                    sda_oe  <= 1'b1;
                    sda_out <= 1'b1;
                end
                2'd1: begin
                    if (is_restart) begin
                        scl <= 1'b1;
                    end else begin
                        sda_out <= 1'b0;  // START, scl already high
                    end
                end
                2'd2: begin
                    if (is_restart) begin
                        sda_out <= 1'b0;  // repeated START
                    end
                end
                default: scl <= 1'b0;
            endcase
        end else begin
            case (bit_cnt[1:0])
                2'd0: begin
                    if (bit_cnt < 6'd32) begin
                        sda_oe  <= !is_rx;
                        sda_out <= is_rx ? 1'b1 : phase_req.tx_byte[bit_idx];
                    end else begin
                        sda_oe  <= is_rx;  // NACK on rx, release for slave ack on tx
                        sda_out <= 1'b1;
                    end
                end
                2'd1:    scl <= 1'b1;
                2'd3:    scl <= 1'b0;
                default: ;
            endcase
        end
    end

    // --------------------
    // receive
    // --------------------
    always_ff @(posedge dri_clk) begin
        if (phase_valid && is_rx && (bit_cnt[1:0] == 2'd1) && (bit_cnt < 6'd32)) begin
            rx_shift <= {rx_shift[6:0], sda_in};  // msb arrives first
        end
    end

    assign rx_byte = rx_shift;

    a_req_stable : assert property (@(posedge dri_clk) disable iff (!rst_n)
        (phase_valid && !phase_done) |=> $stable(phase_req));

endmodule

/* rtl/i2c_master.sv */
`timescale 1ns/1ps

module i2c_master #(
    parameter i2c_pkg::slave_addr_t SLAVE_ADDR = 7'b1010000
) (
    input  logic               dri_clk,    // 4x scl rate
    input  logic               rst_n,

    input  logic               i2c_exec,
    input  i2c_pkg::i2c_cmd_t  i2c_cmd,
    output i2c_pkg::data_t     i2c_data_r,
    output logic               i2c_done,

    output logic               scl,
    inout  wire                sda
);

    import i2c_pkg::*;

    phase_req_t phase_req;
    logic       phase_valid;
    logic       phase_done;
    data_t      rx_byte;
    logic       sda_out;
    logic       sda_oe;
    logic       sda_in;

    // --------------------
    // sda pad
    // --------------------
    assign sda    = sda_oe ? sda_out : 1'bz;  // released when slave drives
    assign sda_in = sda;

    i2c_txn_seq #(
        .SLAVE_ADDR (SLAVE_ADDR)
    ) u_txn_seq (
        .dri_clk     (dri_clk),
        .rst_n       (rst_n),
        .i2c_exec    (i2c_exec),
        .i2c_cmd     (i2c_cmd),
        .phase_req   (phase_req),
        .phase_valid (phase_valid),
        .phase_done  (phase_done),
        .rx_byte     (rx_byte),
        .i2c_data_r  (i2c_data_r),
        .i2c_done    (i2c_done)
    );

    i2c_bit_engine u_bit_engine (
        .dri_clk     (dri_clk),
        .rst_n       (rst_n),
        .phase_req   (phase_req),
        .phase_valid (phase_valid),
        .phase_done  (phase_done),
        .rx_byte     (rx_byte),
        .scl         (scl),
        .sda_out     (sda_out),
        .sda_oe      (sda_oe),
        .sda_in      (sda_in)
    );

endmodule

/* dv/i2c_slave_model.sv */
`timescale 1ns/1ps

module i2c_slave_model #(
    parameter i2c_pkg::slave_addr_t SLAVE_ADDR = 7'b1010000
) (
    input  logic                 dri_clk,       // paces sda changes after scl falls
    input  logic                 scl,
    inout  wire                  sda,

    output int                   txn_cnt,       // completed START..STOP transfers
    output i2c_pkg::data_t       addr_byte_w,   // byte after START
    output i2c_pkg::data_t       addr_byte_r,   // byte after repeated START
    output logic                 restart_seen,
    output int                   addr_len,      // word address bytes received
    output i2c_pkg::word_addr_t  word_addr,
    output i2c_pkg::data_t       data_byte      // written byte or byte sent back
);

    import i2c_pkg::*;

    data_t mem [0:65535];
    data_t wr_q [$];    // bytes after the address byte
    data_t shift;
    data_t tx_byte;
    int    bit_cnt;
    logic  in_txn;
    logic  first_byte;
    logic  selected;
    logic  rd_pending;
    logic  reading;     // slave owns sda for data bits
    logic  sda_low;

    assign sda = sda_low ? 1'b0 : 1'bz;

    function automatic word_addr_t addr_from_queue(input int n);
        if (n == 2) begin
            return {wr_q[0], wr_q[1]};
        end
        return (n == 1) ? {8'h00, wr_q[0]} : '0;
    endfunction

    initial begin
        for (int a = 0; a < 65536; a++) begin
            mem[a] = a[15:8] ^ a[7:0] ^ 8'h3c;
        end
        txn_cnt = 0;
        in_txn  = 1'b0;
        reading = 1'b0;
        sda_low = 1'b0;
        bit_cnt = 0;
    end

    // --------------------
    // START / STOP
    // --------------------
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            if (in_txn) begin
                restart_seen = 1'b1;                    // word address is complete
                addr_len     = wr_q.size();
                word_addr    = addr_from_queue(addr_len);
            end else begin
                restart_seen = 1'b0;
                addr_len     = 0;
                word_addr    = '0;
                addr_byte_w  = '0;
                addr_byte_r  = '0;
                data_byte    = '0;
            end
            wr_q.delete();
            in_txn     = 1'b1;
            first_byte = 1'b1;
            rd_pending = 1'b0;
            reading    = 1'b0;
            bit_cnt    = 0;
        end
    end

    always @(posedge sda) begin
        if ((scl === 1'b1) && in_txn) begin
            if (!restart_seen && (wr_q.size() >= 2)) begin
                addr_len  = wr_q.size() - 1;            // last byte is data
                word_addr = addr_from_queue(addr_len);
                data_byte = wr_q[wr_q.size() - 1];
                if (selected) begin
                    mem[word_addr] = data_byte;
                end
            end
            txn_cnt = txn_cnt + 1;
            in_txn  = 1'b0;
            reading = 1'b0;
        end
    end

    // --------------------
    // bits and ack
    // --------------------
    always @(posedge scl) begin
        if (in_txn) begin
            if (bit_cnt < 8) begin
                shift   = {shift[6:0], sda};
                bit_cnt = bit_cnt + 1;
                if (bit_cnt == 8) begin
                    if (first_byte) begin
                        first_byte = 1'b0;
                        selected   = (shift[7:1] == SLAVE_ADDR);
                        rd_pending = shift[0];
                        if (restart_seen) begin
                            addr_byte_r = shift;
                        end else begin
                            addr_byte_w = shift;
                        end
                    end else if (reading) begin
                        data_byte = shift;              // our own byte as seen on the bus
                    end else begin
                        wr_q.push_back(shift);
                    end
                end
            end else begin
                bit_cnt = 0;                            // ack clock
                if (reading && sda) begin
                    reading = 1'b0;                     // master NACK ends the read
                end
                if (rd_pending && selected) begin
                    reading = 1'b1;
                    tx_byte = mem[word_addr];
                end
                rd_pending = 1'b0;
            end
        end
    end

    always @(negedge scl) begin
        logic drive_low;
        sda_low   = 1'b0;
        drive_low = 1'b0;
        if (in_txn) begin
            if (bit_cnt == 8) begin
                drive_low = !reading && selected;       // ack
            end else if (reading) begin
                drive_low = !tx_byte[7 - bit_cnt];
            end
        end
        if (drive_low) begin
            @(posedge dri_clk);                         // master lets go on this edge
            #1;
            sda_low = 1'b1;
        end
    end

endmodule

/* dv/i2c_master_tb.sv */
`timescale 1ns/1ps

module i2c_master_tb;

    import i2c_pkg::*;

    localparam slave_addr_t SLAVE_ADDR = 7'h52;
    localparam int NUM_CMDS = 40;
    localparam int TIMEOUT_CYCLES = 10 + NUM_CMDS * (205 + 12) + 100;  // idle gap and done cycles

    logic       dri_clk;
    logic       rst_n;
    logic       i2c_exec;
    i2c_cmd_t   i2c_cmd;
    data_t      i2c_data_r;
    logic       i2c_done;
    logic       scl;
    wire        sda;

    int          slv_txn_cnt;
    data_t       slv_addr_w;
    data_t       slv_addr_r;
    logic        slv_restart;
    int          slv_addr_len;
    word_addr_t  slv_word_addr;
    data_t       slv_data;

    logic [15:0] lfsr_state;
    int          cycle_cnt;
    data_t       model_mem [0:65535];

    pullup (sda);

    i2c_master #(
        .SLAVE_ADDR (SLAVE_ADDR)
    ) i_i2c_master (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .i2c_exec   (i2c_exec),
        .i2c_cmd    (i2c_cmd),
        .i2c_data_r (i2c_data_r),
        .i2c_done   (i2c_done),
        .scl        (scl),
        .sda        (sda)
    );

    i2c_slave_model #(
        .SLAVE_ADDR (SLAVE_ADDR)
    ) u_slave (
        .dri_clk      (dri_clk),
        .scl          (scl),
        .sda          (sda),
        .txn_cnt      (slv_txn_cnt),
        .addr_byte_w  (slv_addr_w),
        .addr_byte_r  (slv_addr_r),
        .restart_seen (slv_restart),
        .addr_len     (slv_addr_len),
        .word_addr    (slv_word_addr),
        .data_byte    (slv_data)
    );

    initial begin
        dri_clk = 1'b0;
        forever #2 dri_clk = ~dri_clk;
    end

    // --------------------
    // helpers
    // --------------------
    function automatic logic lfsr_step();
        logic out;
        out        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 16'hb400;
        end
        return out;
    endfunction

    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsr_step()};
        end
        return v;
    endfunction

    task automatic stop_on_failure();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        stop_on_failure();
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        stop_on_failure();
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge dri_clk);
            i2c_exec <= 1'b0;
            @(negedge dri_clk);
            assert (i2c_done == 1'b0) else report_mismatch("i2c_done", i2c_done, 0);
        end
    endtask

    task automatic run_command(input int idx);
        i2c_cmd_t   cmd;
        i2c_cmd_t   junk;
        word_addr_t eff_addr;
        data_t      exp_data;
        int         exp_lat;
        int         edges;
        logic       done_seen;

        cmd.rh_wl    = lfsr_step();
        cmd.bit_ctrl = lfsr_step();
        cmd.addr     = {7'h00, lfsr_step(), 4'h0, 4'(take_bits(4))};  // small window
        cmd.wdata    = 8'(take_bits(8));
        eff_addr = cmd.bit_ctrl ? cmd.addr : {8'h00, cmd.addr[7:0]};
        // start+addr, word address bytes, data or restart+read, stop
        exp_lat = 40 + (cmd.bit_ctrl ? 72 : 36) + (cmd.rh_wl ? 76 : 36) + 17;

        @(posedge dri_clk);
        i2c_exec <= 1'b1;
        i2c_cmd  <= cmd;
        @(posedge dri_clk);                              // accepting edge
        i2c_exec <= 1'b0;
        edges     = 0;
        done_seen = 1'b0;
        while (!done_seen && (edges < exp_lat + 10)) begin
            @(posedge dri_clk);
            edges++;
            if ((edges == exp_lat) || ((edges + 1 < exp_lat) && (take_bits(3) == 0))) begin
                junk.rh_wl    = lfsr_step();             // exec while busy or in the done cycle
                junk.bit_ctrl = lfsr_step();
                junk.addr     = take_bits(16);
                junk.wdata    = 8'(take_bits(8));
                i2c_exec <= 1'b1;
                i2c_cmd  <= junk;
            end else begin
                i2c_exec <= 1'b0;
            end
            @(negedge dri_clk);
            done_seen = i2c_done;
        end
        assert (done_seen) else report_problem("i2c_done never pulsed for a command");
        assert (edges == exp_lat) else report_mismatch("i2c_done latency", edges, exp_lat);

        exp_data = cmd.rh_wl ? model_mem[eff_addr] : cmd.wdata;
        assert (slv_txn_cnt == idx + 1) else report_mismatch("txn_cnt", slv_txn_cnt, idx + 1);
        assert (slv_addr_w == {SLAVE_ADDR, 1'b0})
            else report_mismatch("addr_byte_w", slv_addr_w, {SLAVE_ADDR, 1'b0});
        assert (slv_restart == cmd.rh_wl)
            else report_mismatch("restart_seen", slv_restart, cmd.rh_wl);
        assert (slv_addr_len == (cmd.bit_ctrl ? 2 : 1))
            else report_mismatch("addr_len", slv_addr_len, cmd.bit_ctrl ? 2 : 1);
        assert (slv_word_addr == eff_addr)
            else report_mismatch("word_addr", slv_word_addr, eff_addr);
        assert (slv_data == exp_data) else report_mismatch("data_byte", slv_data, exp_data);
        if (cmd.rh_wl) begin
            assert (slv_addr_r == {SLAVE_ADDR, 1'b1})
                else report_mismatch("addr_byte_r", slv_addr_r, {SLAVE_ADDR, 1'b1});
            assert (i2c_data_r == exp_data)
                else report_mismatch("i2c_data_r", i2c_data_r, exp_data);
        end else begin
            model_mem[eff_addr] = cmd.wdata;
        end

        @(posedge dri_clk);
        i2c_exec <= 1'b0;
        @(negedge dri_clk);
        assert (i2c_done == 1'b0) else report_mismatch("i2c_done", i2c_done, 0);  // one cycle
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        lfsr_state = 16'd37;
        cycle_cnt  = 0;
        rst_n      = 1'b0;
        i2c_exec   = 1'b0;
        i2c_cmd    = '0;
        for (int a = 0; a < 65536; a++) begin
            model_mem[a] = a[15:8] ^ a[7:0] ^ 8'h3c;    // same fill as the device
        end
        repeat (10) @(posedge dri_clk);
        rst_n <= 1'b1;
        @(negedge dri_clk);
        assert (scl === 1'b1) else report_mismatch("scl", scl, 1);
        assert (sda === 1'b1) else report_mismatch("sda", sda, 1);
        assert (i2c_done === 1'b0) else report_mismatch("i2c_done", i2c_done, 0);

        for (int i = 0; i < NUM_CMDS; i++) begin
            idle_cycles(1 + take_bits(3));
            run_command(i);
        end
        idle_cycles(20);
        assert (slv_txn_cnt == NUM_CMDS) else report_mismatch("txn_cnt", slv_txn_cnt, NUM_CMDS);
        $display("Testbench passed");
        $finish;
    end

    always @(posedge dri_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            report_problem("timeout: the commands did not finish within the cycle limit");
        end
    end

endmodule

/* i2c_master.f */
common/i2c_pkg.sv
i2c/i2c_txn_seq.sv
i2c/i2c_bit_engine.sv
rtl/i2c_master.sv
dv/i2c_slave_model.sv
dv/i2c_master_tb.sv
